// File: Makefile
VERILATOR ?= verilator
TOP       ?= tex_mem_unit_tb
FILELIST  ?= tex_mem_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tex_mem_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "tex_consts.svh"

module tex_mem_unit_tb;

    localparam int NUM_REQ        = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 64;
    localparam int NL             = `TEX_NUM_LANES;
    localparam int NT             = `TEX_NUM_TEXELS;

    logic clk = 1'b0;
    logic rst_n;
    logic req_valid;
    logic [NL-1:0] req_tmask;
    tex_pkg::filter_e req_filter;
    tex_pkg::stride_e req_lgstride;
    logic [NL-1:0][`TEX_ADDR_BITS-1:0] req_baseaddr;
    logic [NL-1:0][NT-1:0][`TEX_ADDR_BITS-1:0] req_addr;
    logic [`TEX_INFO_BITS-1:0] req_info;
    wire req_ready;
    wire rsp_valid;
    wire [NL-1:0] rsp_tmask;
    wire [NL-1:0][NT-1:0][`TEX_DATA_BITS-1:0] rsp_data;
    wire [`TEX_INFO_BITS-1:0] rsp_info;
    logic rsp_ready;
    wire cache_req_valid;
    wire [`TEX_WORD_ADDR_BITS-1:0] cache_req_addr;
    wire [`TEX_TAG_BITS-1:0] cache_req_tag;
    logic cache_req_ready;
    logic cache_rsp_valid;
    logic [`TEX_DATA_BITS-1:0] cache_rsp_data;
    logic [`TEX_TAG_BITS-1:0] cache_rsp_tag;

    // reference model state per request number
    logic [`TEX_DATA_BITS-1:0] exp_data [NUM_REQ][NL][NT];
    logic [NL-1:0] exp_tmask [NUM_REQ];
    logic [`TEX_INFO_BITS-1:0] exp_info [NUM_REQ];
    logic [4:0] exp_cnt [NUM_REQ];
    logic [4:0] act_cnt [NUM_REQ];
    int slot_req [`TEX_PENDING];
    logic [`TEX_SLOT_BITS-1:0] tail_slot;

    // memory responder with up to four reads in flight
    logic [`TEX_WORD_ADDR_BITS-1:0] pend_addr [4];
    logic [`TEX_TAG_BITS-1:0] pend_tag [4];
    int pend_due [4];
    int pend_cnt;

    logic [31:0] rng;
    int cyc, wd_cycles, sent, acc_cnt, rsp_done, gap;
    logic req_pending, draining;
    int n_value_err, n_other_err;

    tex_mem_unit DUT (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_tmask(req_tmask), .req_filter(req_filter),
        .req_lgstride(req_lgstride), .req_baseaddr(req_baseaddr), .req_addr(req_addr),
        .req_info(req_info), .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp_tmask(rsp_tmask), .rsp_data(rsp_data),
        .rsp_info(rsp_info), .rsp_ready(rsp_ready),
        .cache_req_valid(cache_req_valid), .cache_req_addr(cache_req_addr),
        .cache_req_tag(cache_req_tag), .cache_req_ready(cache_req_ready),
        .cache_rsp_valid(cache_rsp_valid), .cache_rsp_data(cache_rsp_data),
        .cache_rsp_tag(cache_rsp_tag)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] rand_next();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // nonzero memory contents since the xor constant has bit 31 set
    function automatic logic [31:0] mem_word(input logic [`TEX_WORD_ADDR_BITS-1:0] wa);
        return xorshift32(xorshift32({2'b00, wa} ^ 32'h9e3779b9));
    endfunction

    task automatic check_data(input int lane, input int texel,
                              input logic [`TEX_DATA_BITS-1:0] got,
                              input logic [`TEX_DATA_BITS-1:0] expected);
        if (got !== expected) begin
            n_value_err++;
            $display("** Error: rsp_data[%0d][%0d] got 0x%08h expected 0x%08h (response %0d)",
                     lane, texel, got, expected, rsp_done);
        end
    endtask

    task automatic check_mask(input logic [NL-1:0] got, input logic [NL-1:0] expected);
        if (got !== expected) begin
            n_value_err++;
            $display("** Error: rsp_tmask got 0x%h expected 0x%h (response %0d)",
                     got, expected, rsp_done);
        end
    endtask

    task automatic check_info(input logic [`TEX_INFO_BITS-1:0] got,
                              input logic [`TEX_INFO_BITS-1:0] expected);
        if (got !== expected) begin
            n_value_err++;
            $display("** Error: rsp_info got 0x%02h expected 0x%02h (response %0d)",
                     got, expected, rsp_done);
        end
    endtask

    task automatic check_count(input logic [4:0] got, input logic [4:0] expected);
        if (got !== expected) begin
            n_value_err++;
            $display("** Error: cache_req_valid reads got 0x%02h expected 0x%02h (response %0d)",
                     got, expected, rsp_done);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            n_value_err++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, expected);
        end
    endtask

    task automatic build_expected(input int idx);
        logic [`TEX_ADDR_BITS-1:0] full;
        logic [`TEX_DATA_BITS-1:0] word;
        logic [`TEX_DATA_BITS-1:0] shifted;
        logic [`TEX_WORD_ADDR_BITS-1:0] lane0_word;
        logic texel_on;
        logic shared_word;
        int cnt;
        cnt = 0;
        for (int t = 0; t < NT; t++) begin
            texel_on = (req_filter == tex_pkg::FILTER_BILINEAR) || (t == 0);
            full = req_baseaddr[0] + req_addr[0][t];
            lane0_word = full[`TEX_ADDR_BITS-1:2];
            shared_word = req_tmask[0];
            for (int l = 1; l < NL; l++) begin
                full = req_baseaddr[l] + req_addr[l][t];
                if (req_tmask[l] && (full[`TEX_ADDR_BITS-1:2] != lane0_word))
                    shared_word = 1'b0;
            end
            // a shared word costs a single read
            if (texel_on)
                cnt += shared_word ? 1 : $countones(req_tmask);
            for (int l = 0; l < NL; l++) begin
                full = req_baseaddr[l] + req_addr[l][t];
                word = mem_word(full[`TEX_ADDR_BITS-1:2]);
                shifted = word >> {full[1:0], 3'b000};
                if (!(req_tmask[l] && texel_on))
                    exp_data[idx][l][t] = '0;
                else if (req_lgstride == tex_pkg::STRIDE_BYTE)
                    exp_data[idx][l][t] = {24'd0, shifted[7:0]};
                else if (req_lgstride == tex_pkg::STRIDE_HALF)
                    exp_data[idx][l][t] = {16'd0, shifted[15:0]};
                else
                    exp_data[idx][l][t] = word;
            end
        end
        exp_tmask[idx] = req_tmask;
        exp_info[idx]  = req_info;
        exp_cnt[idx]   = 5'(cnt);
        act_cnt[idx]   = '0;
    endtask

    task automatic gen_request(input int idx);
        logic [31:0] r;
        logic [31:0] amask;
        logic [31:0] common_base;
        logic [31:0] texel_off [NT];
        logic shared;
        r = rand_next();
        req_tmask  = r[NL-1:0];
        req_filter = r[4] ? tex_pkg::FILTER_BILINEAR : tex_pkg::FILTER_POINT;
        req_info   = r[8 +: `TEX_INFO_BITS];
        shared     = (r[18:16] < 3'd3);
        // offsets stay naturally aligned to the texel size
        case (r[21:20])
            2'd0: begin
                req_lgstride = tex_pkg::STRIDE_BYTE;
                amask        = 32'hffff_ffff;
            end
            2'd1: begin
                req_lgstride = tex_pkg::STRIDE_HALF;
                amask        = 32'hffff_fffe;
            end
            default: begin
                req_lgstride = tex_pkg::STRIDE_WORD;
                amask        = 32'hffff_fffc;
            end
        endcase
        common_base = rand_next() & 32'hffff_fffc;
        for (int t = 0; t < NT; t++)
            texel_off[t] = rand_next() & 32'h0000_03fc;
        for (int l = 0; l < NL; l++) begin
            req_baseaddr[l] = shared ? common_base : (rand_next() & 32'hffff_fffc);
            for (int t = 0; t < NT; t++)
                req_addr[l][t] = shared ? ((texel_off[t] | (rand_next() & 32'h3)) & amask)
                                        : (rand_next() & 32'h0000_0fff & amask);
        end
        build_expected(idx);
    endtask

    task automatic sample_outputs();
        if (req_valid && req_ready) begin
            slot_req[tail_slot] = acc_cnt;
            tail_slot = tail_slot + 2'd1;
            acc_cnt++;
            req_pending = 1'b0;
        end
        if (cache_req_valid && cache_req_ready) begin
            pend_addr[pend_cnt] = cache_req_addr;
            pend_tag[pend_cnt]  = cache_req_tag;
            pend_due[pend_cnt]  = cyc + int'(rand_next() % 8);
            pend_cnt++;
            act_cnt[slot_req[cache_req_tag[`TEX_TAG_BITS-1 -: `TEX_SLOT_BITS]]] += 5'd1;
        end
        if (rsp_valid && rsp_ready) begin
            if (rsp_done >= NUM_REQ) begin
                n_other_err++;
                $display("extra response seen after all requests had completed");
            end else begin
                for (int l = 0; l < NL; l++)
                    for (int t = 0; t < NT; t++)
                        check_data(l, t, rsp_data[l][t], exp_data[rsp_done][l][t]);
                check_mask(rsp_tmask, exp_tmask[rsp_done]);
                check_info(rsp_info, exp_info[rsp_done]);
                check_count(act_cnt[rsp_done], exp_cnt[rsp_done]);
                rsp_done++;
            end
        end
        cyc++;
    endtask

    task automatic drive_inputs();
        int n_elig;
        int pick;
        int sel;
        logic [31:0] r;
        n_elig = 0;
        sel = -1;
        cache_rsp_valid = 1'b0;
        for (int k = 0; k < pend_cnt; k++)
            if (pend_due[k] <= cyc) n_elig++;
        // random pick among ripe reads makes replies return out of order
        if (n_elig > 0) begin
            pick = int'(rand_next() % n_elig);
            for (int k = 0; k < pend_cnt; k++) begin
                if (pend_due[k] <= cyc) begin
                    if (pick == 0) sel = k;
                    pick--;
                end
            end
            cache_rsp_valid = 1'b1;
            cache_rsp_data  = mem_word(pend_addr[sel]);
            cache_rsp_tag   = pend_tag[sel];
            for (int k = sel; k < pend_cnt - 1; k++) begin
                pend_addr[k] = pend_addr[k+1];
                pend_tag[k]  = pend_tag[k+1];
                pend_due[k]  = pend_due[k+1];
            end
            pend_cnt--;
        end
        cache_req_ready = (rand_next() % 4 != 0) && (pend_cnt < 4);
        rsp_ready = draining || (rand_next() % 4 != 0);
        if (!req_pending) begin
            req_valid = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (sent < NUM_REQ) begin
                gen_request(sent);
                sent++;
                req_valid = 1'b1;
                req_pending = 1'b1;
                r = rand_next();
                gap = r[0] ? 0 : int'(r[3:1] % 5);
            end
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        sample_outputs();
        #1;
        drive_inputs();
    endtask

    always @(posedge clk) begin
        wd_cycles++;
        if (wd_cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d responses",
                     wd_cycles, rsp_done, NUM_REQ);
            $display("%0d value errors, %0d other errors", n_value_err, n_other_err);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rng = 32'hb18ac92a;
        {cyc, wd_cycles, sent, acc_cnt, rsp_done, gap, pend_cnt} = '0;
        {n_value_err, n_other_err} = '0;
        tail_slot = '0;
        req_pending = 1'b0;
        draining = 1'b0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_tmask = '0;
        req_filter = tex_pkg::FILTER_POINT;
        req_lgstride = tex_pkg::STRIDE_BYTE;
        req_baseaddr = '0;
        req_addr = '0;
        req_info = '0;
        rsp_ready = 1'b0;
        cache_req_ready = 1'b0;
        cache_rsp_valid = 1'b0;
        cache_rsp_data = '0;
        cache_rsp_tag = '0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        check_level("req_ready", req_ready, 1'b1);
        check_level("rsp_valid", rsp_valid, 1'b0);
        check_level("cache_req_valid", cache_req_valid, 1'b0);
        #1;
        drive_inputs();
        while (rsp_done < NUM_REQ)
            run_cycle();
        // drain with no back-pressure to catch stray responses or reads
        draining = 1'b1;
        repeat (16) run_cycle();
        if (pend_cnt != 0) begin
            n_other_err++;
            $display("%0d cache reads still waiting for a reply at the end", pend_cnt);
        end
        check_level("cache_req_valid", cache_req_valid, 1'b0);
        check_level("req_ready", req_ready, 1'b1);
        $display("%0d responses checked, %0d value errors, %0d other errors",
                 rsp_done, n_value_err, n_other_err);
        if (n_value_err == 0 && n_other_err == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tex_mem_unit.f
+incdir+verilog
verilog/tex_pkg.sv
verilog/tex_cache_pkg.sv
verilog/tex_addr_gen.sv
verilog/tex_mem_sched.sv
verilog/tex_rsp_format.sv
verilog/tex_mem_unit.sv
test/tex_mem_unit_tb.sv

// File: verilog/tex_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "tex_consts.svh"

module tex_addr_gen (
    input  wire [`TEX_NUM_LANES-1:0]                                req_tmask,
    input  wire tex_pkg::filter_e                                   req_filter,
    input  wire [`TEX_NUM_LANES-1:0][`TEX_ADDR_BITS-1:0]            req_baseaddr,
    input  wire [`TEX_NUM_LANES-1:0][`TEX_NUM_TEXELS-1:0][`TEX_ADDR_BITS-1:0] req_addr,
    output logic [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][`TEX_WORD_ADDR_BITS-1:0] word_addr,
    output logic [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][1:0]     align,
    output logic [`TEX_NUM_TEXELS-1:0]                              dups,
    output logic [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0]          fetch_mask
);

    // byte address sums regrouped texel first
    for (genvar l = 0; l < `TEX_NUM_LANES; l++) begin : g_lane
        for (genvar t = 0; t < `TEX_NUM_TEXELS; t++) begin : g_texel
            wire [`TEX_ADDR_BITS-1:0] full_addr;

            assign full_addr       = req_baseaddr[l] + req_addr[l][t];
            assign word_addr[t][l] = full_addr[`TEX_ADDR_BITS-1:2];
            assign align[t][l]     = full_addr[1:0];
        end
    end

    for (genvar t = 0; t < `TEX_NUM_TEXELS; t++) begin : g_dup
        wire [`TEX_NUM_LANES-1:1] same_word;
        wire                      texel_on;

        // inactive lanes never break sharing
        for (genvar l = 1; l < `TEX_NUM_LANES; l++) begin : g_cmp
            assign same_word[l] = (word_addr[t][l] == word_addr[t][0]) || !req_tmask[l];
        end

        assign dups[t]  = req_tmask[0] && (&same_word);
        // point filter only reads texel 0
        assign texel_on = (req_filter == tex_pkg::FILTER_BILINEAR) || (t == 0);

        for (genvar l = 0; l < `TEX_NUM_LANES; l++) begin : g_mask
            assign fetch_mask[t][l] = req_tmask[l] && texel_on && (!dups[t] || (l == 0));
        end
    end

endmodule

`default_nettype wire

// File: verilog/tex_cache_pkg.sv
`default_nettype none
`include "tex_consts.svh"

package tex_cache_pkg;

    typedef enum logic [1:0] {
        SLOT_FREE,
        SLOT_WAIT,
        SLOT_DONE
    } slot_state_e;

    // word position is texel * lanes + lane
    localparam int NUM_WORDS     = `TEX_NUM_LANES * `TEX_NUM_TEXELS;
    localparam int WORD_IDX_BITS = $clog2(NUM_WORDS);

    typedef logic [WORD_IDX_BITS-1:0] word_idx_t;

endpackage

`default_nettype wire

// File: verilog/tex_consts.svh
`ifndef TEX_CONSTS_SVH
`define TEX_CONSTS_SVH

// request geometry
`define TEX_NUM_LANES       4
`define TEX_NUM_TEXELS      4
`define TEX_INFO_BITS       8

// slots in flight and the matching pointer width
`define TEX_PENDING         4
`define TEX_SLOT_BITS       2

// byte and word addresses, 32-bit data words
`define TEX_ADDR_BITS       32
`define TEX_WORD_ADDR_BITS  30
`define TEX_DATA_BITS       32

// cache tag is slot number then word index
`define TEX_TAG_BITS        6

`endif

// File: verilog/tex_mem_sched.sv
`timescale 1ns/1ps
`default_nettype none
`include "tex_consts.svh"

module tex_mem_sched (
    input  wire                           clk,
    input  wire                           rst_n,

    input  wire                           req_valid,
    input  wire [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][`TEX_WORD_ADDR_BITS-1:0] word_addr,
    input  wire [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][1:0] align,
    input  wire [`TEX_NUM_TEXELS-1:0]     dups,
    input  wire [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0] fetch_mask,
    input  wire [`TEX_NUM_LANES-1:0]      req_tmask,
    input  wire tex_pkg::stride_e         req_lgstride,
    input  wire [`TEX_INFO_BITS-1:0]      req_info,
    output logic                          req_ready,

    output logic                          cache_req_valid,
    output logic [`TEX_WORD_ADDR_BITS-1:0] cache_req_addr,
    output logic [`TEX_TAG_BITS-1:0]      cache_req_tag,
    input  wire                           cache_req_ready,

    input  wire                           cache_rsp_valid,
    input  wire [`TEX_DATA_BITS-1:0]      cache_rsp_data,
    input  wire [`TEX_TAG_BITS-1:0]       cache_rsp_tag,

    output logic                          sched_valid,
    output logic [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][`TEX_DATA_BITS-1:0] sched_data,
    output logic [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0] sched_mask,
    output logic [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][1:0] sched_align,
    output logic [`TEX_NUM_TEXELS-1:0]    sched_dups,
    output tex_pkg::stride_e              sched_lgstride,
    output logic [`TEX_NUM_LANES-1:0]     sched_tmask,
    output logic [`TEX_INFO_BITS-1:0]     sched_info,
    input  wire                           sched_ready
);

    localparam int NW       = tex_cache_pkg::NUM_WORDS;
    localparam int CNT_BITS = tex_cache_pkg::WORD_IDX_BITS + 1;

    // slot control
    tex_cache_pkg::slot_state_e slot_state [`TEX_PENDING];
    logic [NW-1:0]              slot_fetch [`TEX_PENDING];
    logic [CNT_BITS-1:0]        slot_cnt   [`TEX_PENDING];
    logic [`TEX_SLOT_BITS-1:0]  head;
    logic [`TEX_SLOT_BITS-1:0]  tail;

    // slot payload
    logic [NW-1:0][`TEX_WORD_ADDR_BITS-1:0]   slot_addr  [`TEX_PENDING];
    logic [NW-1:0][`TEX_DATA_BITS-1:0]        slot_data  [`TEX_PENDING];
    logic [NW-1:0]                            slot_mask  [`TEX_PENDING];
    logic [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][1:0] slot_align [`TEX_PENDING];
    logic [`TEX_NUM_TEXELS-1:0]               slot_dups  [`TEX_PENDING];
    tex_pkg::stride_e                         slot_stride [`TEX_PENDING];
    logic [`TEX_NUM_LANES-1:0]                slot_tmask [`TEX_PENDING];
    logic [`TEX_INFO_BITS-1:0]                slot_info  [`TEX_PENDING];

    wire [NW-1:0]               fetch_flat;
    logic [CNT_BITS-1:0]        req_cnt;
    logic                       issue_found;
    logic [`TEX_SLOT_BITS-1:0]  issue_slot;
    logic [`TEX_SLOT_BITS-1:0]  scan_slot;
    tex_cache_pkg::word_idx_t   issue_idx;
    logic [`TEX_SLOT_BITS-1:0]  rsp_slot;
    tex_cache_pkg::word_idx_t   rsp_idx;
    wire                        req_fire;
    wire                        issue_fire;
    wire                        retire_fire;

    assign fetch_flat = fetch_mask;

    always_comb begin
        req_cnt = '0;
        for (int w = 0; w < NW; w++) begin
            req_cnt = req_cnt + CNT_BITS'(fetch_flat[w]);
        end
    end

    // oldest slot with bits left, then its lowest word
    always_comb begin
        issue_found = 1'b0;
        issue_slot  = head;
        scan_slot   = head;
        issue_idx   = '0;
        for (int k = 0; k < `TEX_PENDING; k++) begin
            scan_slot = head + `TEX_SLOT_BITS'(k);
            if (!issue_found && (|slot_fetch[scan_slot])) begin
                issue_found = 1'b1;
                issue_slot  = scan_slot;
            end
        end
        for (int w = NW - 1; w >= 0; w--) begin
            if (slot_fetch[issue_slot][w]) begin
                issue_idx = tex_cache_pkg::word_idx_t'(w);
            end
        end
    end

    assign cache_req_valid = issue_found;
    assign cache_req_addr  = slot_addr[issue_slot][issue_idx];
    assign cache_req_tag   = {issue_slot, issue_idx};
    assign {rsp_slot, rsp_idx} = cache_rsp_tag;

    // allocation and retirement are both in order
    assign req_ready   = (slot_state[tail] == tex_cache_pkg::SLOT_FREE);
    assign sched_valid = (slot_state[head] == tex_cache_pkg::SLOT_DONE);

    assign req_fire    = req_valid && req_ready;
    assign issue_fire  = cache_req_valid && cache_req_ready;
    assign retire_fire = sched_valid && sched_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            for (int s = 0; s < `TEX_PENDING; s++) begin
                slot_state[s] <= tex_cache_pkg::SLOT_FREE;
                slot_fetch[s] <= '0;
                slot_cnt[s]   <= '0;
            end
        end else begin
            if (req_fire) begin
                // nothing to fetch means done right away
                slot_state[tail] <= (fetch_flat == '0) ? tex_cache_pkg::SLOT_DONE
                                                       : tex_cache_pkg::SLOT_WAIT;
                slot_fetch[tail] <= fetch_flat;
                slot_cnt[tail]   <= req_cnt;
                tail             <= tail + 1'b1;
            end
            if (issue_fire) begin
                slot_fetch[issue_slot][issue_idx] <= 1'b0;
            end
            if (cache_rsp_valid) begin
                slot_cnt[rsp_slot] <= slot_cnt[rsp_slot] - 1'b1;
                if (slot_cnt[rsp_slot] == CNT_BITS'(1)) begin
                    slot_state[rsp_slot] <= tex_cache_pkg::SLOT_DONE;
                end
            end
            if (retire_fire) begin
                slot_state[head] <= tex_cache_pkg::SLOT_FREE;
                head             <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            slot_addr[tail]   <= word_addr;
            slot_mask[tail]   <= fetch_flat;
            slot_align[tail]  <= align;
            slot_dups[tail]   <= dups;
            slot_stride[tail] <= req_lgstride;
            slot_tmask[tail]  <= req_tmask;
            slot_info[tail]   <= req_info;
        end
        if (cache_rsp_valid) begin
            slot_data[rsp_slot][rsp_idx] <= cache_rsp_data;
        end
    end

    assign sched_data     = slot_data[head];
    assign sched_mask     = slot_mask[head];
    assign sched_align    = slot_align[head];
    assign sched_dups     = slot_dups[head];
    assign sched_lgstride = slot_stride[head];
    assign sched_tmask    = slot_tmask[head];
    assign sched_info     = slot_info[head];

endmodule

`default_nettype wire

// File: verilog/tex_mem_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "tex_consts.svh"

module tex_mem_unit (
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire                          req_valid,
    input  wire [`TEX_NUM_LANES-1:0]     req_tmask,
    input  wire tex_pkg::filter_e        req_filter,
    input  wire tex_pkg::stride_e        req_lgstride,
    input  wire [`TEX_NUM_LANES-1:0][`TEX_ADDR_BITS-1:0] req_baseaddr,
    input  wire [`TEX_NUM_LANES-1:0][`TEX_NUM_TEXELS-1:0][`TEX_ADDR_BITS-1:0] req_addr,
    input  wire [`TEX_INFO_BITS-1:0]     req_info,
    output logic                         req_ready,

    output logic                         rsp_valid,
    output logic [`TEX_NUM_LANES-1:0]    rsp_tmask,
    output logic [`TEX_NUM_LANES-1:0][`TEX_NUM_TEXELS-1:0][`TEX_DATA_BITS-1:0] rsp_data,
    output logic [`TEX_INFO_BITS-1:0]    rsp_info,
    input  wire                          rsp_ready,

    output logic                         cache_req_valid,
    output logic [`TEX_WORD_ADDR_BITS-1:0] cache_req_addr,
    output logic [`TEX_TAG_BITS-1:0]     cache_req_tag,
    input  wire                          cache_req_ready,

    input  wire                          cache_rsp_valid,
    input  wire [`TEX_DATA_BITS-1:0]     cache_rsp_data,
    input  wire [`TEX_TAG_BITS-1:0]      cache_rsp_tag
);

    wire [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][`TEX_WORD_ADDR_BITS-1:0] word_addr;
    wire [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][1:0] align;
    wire [`TEX_NUM_TEXELS-1:0]                          dups;
    wire [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0]      fetch_mask;

    wire                                                sched_valid;
    wire [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][`TEX_DATA_BITS-1:0] sched_data;
    wire [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0]      sched_mask;
    wire [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][1:0] sched_align;
    wire [`TEX_NUM_TEXELS-1:0]                          sched_dups;
    tex_pkg::stride_e                                   sched_lgstride;
    wire [`TEX_NUM_LANES-1:0]                           sched_tmask;
    wire [`TEX_INFO_BITS-1:0]                           sched_info;
    wire                                                sched_ready;

    tex_addr_gen u_addr_gen (
        .req_tmask    (req_tmask),
        .req_filter   (req_filter),
        .req_baseaddr (req_baseaddr),
        .req_addr     (req_addr),
        .word_addr    (word_addr),
        .align        (align),
        .dups         (dups),
        .fetch_mask   (fetch_mask)
    );

    tex_mem_sched u_mem_sched (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .word_addr       (word_addr),
        .align           (align),
        .dups            (dups),
        .fetch_mask      (fetch_mask),
        .req_tmask       (req_tmask),
        .req_lgstride    (req_lgstride),
        .req_info        (req_info),
        .req_ready       (req_ready),
        .cache_req_valid (cache_req_valid),
        .cache_req_addr  (cache_req_addr),
        .cache_req_tag   (cache_req_tag),
        .cache_req_ready (cache_req_ready),
        .cache_rsp_valid (cache_rsp_valid),
        .cache_rsp_data  (cache_rsp_data),
        .cache_rsp_tag   (cache_rsp_tag),
        .sched_valid     (sched_valid),
        .sched_data      (sched_data),
        .sched_mask      (sched_mask),
        .sched_align     (sched_align),
        .sched_dups      (sched_dups),
        .sched_lgstride  (sched_lgstride),
        .sched_tmask     (sched_tmask),
        .sched_info      (sched_info),
        .sched_ready     (sched_ready)
    );

    tex_rsp_format u_rsp_format (
        .clk            (clk),
        .rst_n          (rst_n),
        .sched_valid    (sched_valid),
        .sched_data     (sched_data),
        .sched_mask     (sched_mask),
        .sched_align    (sched_align),
        .sched_dups     (sched_dups),
        .sched_lgstride (sched_lgstride),
        .sched_tmask    (sched_tmask),
        .sched_info     (sched_info),
        .sched_ready    (sched_ready),
        .rsp_valid      (rsp_valid),
        .rsp_tmask      (rsp_tmask),
        .rsp_data       (rsp_data),
        .rsp_info       (rsp_info),
        .rsp_ready      (rsp_ready)
    );

endmodule

`default_nettype wire

// File: verilog/tex_pkg.sv
`default_nettype none

package tex_pkg;

    typedef enum logic {
        FILTER_POINT,
        FILTER_BILINEAR
    } filter_e;

    // log2 of texel size in bytes
    typedef enum logic [1:0] {
        STRIDE_BYTE,
        STRIDE_HALF,
        STRIDE_WORD
    } stride_e;

endpackage

`default_nettype wire

// File: verilog/tex_rsp_format.sv
`timescale 1ns/1ps
`default_nettype none
`include "tex_consts.svh"

module tex_rsp_format (
    input  wire                         clk,
    input  wire                         rst_n,

    input  wire                         sched_valid,
    input  wire [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][`TEX_DATA_BITS-1:0] sched_data,
    input  wire [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0] sched_mask,
    input  wire [`TEX_NUM_TEXELS-1:0][`TEX_NUM_LANES-1:0][1:0] sched_align,
    input  wire [`TEX_NUM_TEXELS-1:0]   sched_dups,
    input  wire tex_pkg::stride_e       sched_lgstride,
    input  wire [`TEX_NUM_LANES-1:0]    sched_tmask,
    input  wire [`TEX_INFO_BITS-1:0]    sched_info,
    output logic                        sched_ready,

    output logic                        rsp_valid,
    output logic [`TEX_NUM_LANES-1:0]   rsp_tmask,
    output logic [`TEX_NUM_LANES-1:0][`TEX_NUM_TEXELS-1:0][`TEX_DATA_BITS-1:0] rsp_data,
    output logic [`TEX_INFO_BITS-1:0]   rsp_info,
    input  wire                         rsp_ready
);

    logic [`TEX_NUM_LANES-1:0][`TEX_NUM_TEXELS-1:0][`TEX_DATA_BITS-1:0] fmt_data;
    wire stall;

    for (genvar l = 0; l < `TEX_NUM_LANES; l++) begin : g_lane
        for (genvar t = 0; t < `TEX_NUM_TEXELS; t++) begin : g_texel
            wire                      src_on;
            wire [`TEX_DATA_BITS-1:0] src_word;
            wire [15:0]               half_sel;
            wire [7:0]                byte_sel;

            // shared words live in lane 0
            assign src_on   = sched_mask[t][l]
                           || (sched_dups[t] && sched_mask[t][0] && sched_tmask[l]);
            assign src_word = (sched_dups[t] ? sched_data[t][0] : sched_data[t][l])
                            & {`TEX_DATA_BITS{src_on}};

            assign half_sel = sched_align[t][l][1] ? src_word[31:16] : src_word[15:0];
            assign byte_sel = sched_align[t][l][0] ? half_sel[15:8] : half_sel[7:0];

            assign fmt_data[l][t] =
                (sched_lgstride == tex_pkg::STRIDE_BYTE) ? {24'd0, byte_sel} :
                (sched_lgstride == tex_pkg::STRIDE_HALF) ? {16'd0, half_sel[15:8], byte_sel} :
                                                           {src_word[31:16], half_sel[15:8], byte_sel};
        end
    end

    // output register holds while downstream stalls
    assign stall       = rsp_valid && !rsp_ready;
    assign sched_ready = !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (!stall) begin
            rsp_valid <= sched_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rsp_tmask <= sched_tmask;
            rsp_data  <= fmt_data;
            rsp_info  <= sched_info;
        end
    end

endmodule

`default_nettype wire
